/* xaui_infrastructure.f */
hw/xaui_pkg.sv
hw/xaui_lane_if.sv
hw/xaui_rx_lane_map.sv
hw/xaui_rx_sync.sv
hw/xaui_port.sv
hw/xaui_infrastructure.sv
verification/xaui_infrastructure_tb.sv

/* Bender.yml */
package:
  name: xaui_infrastructure

sources:
  - files:
      - hw/xaui_pkg.sv
      - hw/xaui_lane_if.sv
      - hw/xaui_rx_lane_map.sv
      - hw/xaui_rx_sync.sv
      - hw/xaui_port.sv
      - hw/xaui_infrastructure.sv
  - target: test
    files:
      - verification/xaui_infrastructure_tb.sv

/* verification/xaui_infrastructure_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module xaui_infrastructure_tb;
  import xaui_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int LOCK_TIMEOUT = 200;
  localparam int FLAT_LANES   = NUM_PORTS * NUM_LANES;

  logic xaui_clk = 1'b0;
  logic reset;
  logic [NUM_PORTS-1:0]            tx_rst;
  logic [NUM_PORTS-1:0]            rx_rst;
  logic [NUM_PORTS*PORT_W-1:0]     txdata;
  logic [NUM_PORTS*PORT_BYTES-1:0] txcharisk;
  logic [NUM_PORTS*PORT_W-1:0]     rx_lane_data;
  logic [NUM_PORTS*PORT_BYTES-1:0] rx_lane_charisk;
  logic [FLAT_LANES-1:0]           encommaalign;
  logic [NUM_PORTS-1:0]            enchansync;
  wire  [NUM_PORTS*PORT_W-1:0]     tx_lane_data;
  wire  [NUM_PORTS*PORT_BYTES-1:0] tx_lane_charisk;
  wire  [NUM_PORTS*PORT_W-1:0]     rxdata;
  wire  [NUM_PORTS*PORT_BYTES-1:0] rxcharisk;
  wire  [NUM_PORTS*PORT_BYTES-1:0] rxcodecomma;
  wire  [NUM_PORTS*PORT_BYTES-1:0] rxcodevalid;
  wire  [FLAT_LANES-1:0]           rxsyncok;
  wire  [FLAT_LANES-1:0]           rxlock;

  integer seed;
  logic   checking;
  // Byte mix in percent where plain data takes the rest
  int     w_comma;
  int     w_align;
  int     w_invalid;

  // Reference model with one register stage per DUT pipeline stage
  port_data_t  m_tx_data  [NUM_PORTS];
  port_mask_t  m_tx_k     [NUM_PORTS];
  port_data_t  m_map_data [NUM_PORTS];
  port_mask_t  m_map_k    [NUM_PORTS];
  port_data_t  m_rx_data  [NUM_PORTS];
  port_mask_t  m_rx_k     [NUM_PORTS];
  port_mask_t  m_rx_comma [NUM_PORTS];
  port_mask_t  m_rx_valid [NUM_PORTS];
  lane_flags_t m_lock     [NUM_PORTS];
  lane_flags_t m_sync     [NUM_PORTS];
  int          m_count    [NUM_PORTS][NUM_LANES];

  xaui_infrastructure uut (
    .xaui_clk        (xaui_clk),
    .reset           (reset),
    .tx_rst          (tx_rst),
    .txdata          (txdata),
    .txcharisk       (txcharisk),
    .tx_lane_data    (tx_lane_data),
    .tx_lane_charisk (tx_lane_charisk),
    .rx_rst          (rx_rst),
    .rx_lane_data    (rx_lane_data),
    .rx_lane_charisk (rx_lane_charisk),
    .encommaalign    (encommaalign),
    .enchansync      (enchansync),
    .rxdata          (rxdata),
    .rxcharisk       (rxcharisk),
    .rxcodecomma     (rxcodecomma),
    .rxcodevalid     (rxcodevalid),
    .rxsyncok        (rxsyncok),
    .rxlock          (rxlock)
  );

  always #(CLK_PERIOD/2) xaui_clk = ~xaui_clk;

  // ========================================
  // Failure reporting and compares
  // ========================================
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input port_data_t exp, input port_data_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flags(input string name, input lane_flags_t exp, input lane_flags_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  // ========================================
  // Model rules
  // ========================================
  // K28.y keeps 11100 in its low five bits and K23.7 to K30.7 carry 111 on top
  function automatic logic legal_k(input logic [BYTE_W-1:0] code);
    return (code[4:0] == 5'd28) ||
           ((code[7:5] == 3'b111) && ((code[4:0] == 5'd23) || (code[4:0] == 5'd27) ||
                                      (code[4:0] == 5'd29) || (code[4:0] == 5'd30)));
  endfunction

  function automatic port_data_t mapped_data(input int p, input port_data_t d);
    port_data_t r;
    int src;
    for (int i = 0; i < NUM_LANES; i++) begin
      src = RX_LANE_STEER[p] ? NUM_LANES - 1 - i : i;
      r[i*LANE_W +: LANE_W] = d[src*LANE_W +: LANE_W];
    end
    return RX_INVERT[p] ? ~r : r;
  endfunction

  function automatic port_mask_t mapped_k(input int p, input port_mask_t k);
    port_mask_t r;
    int src;
    for (int i = 0; i < NUM_LANES; i++) begin
      src = RX_LANE_STEER[p] ? NUM_LANES - 1 - i : i;
      r[i*BYTES_PER_LANE +: BYTES_PER_LANE] = k[src*BYTES_PER_LANE +: BYTES_PER_LANE];
    end
    return r;
  endfunction

  // Advances the model by the clock edge that samples the inputs now driven
  task automatic update_model();
    port_data_t md;
    port_mask_t mk;
    port_mask_t comma;
    port_mask_t align;
    port_mask_t valid;
    logic [BYTE_W-1:0] cur;
    logic clear;
    logic lane_ok;
    logic saw_align;
    int n;
    for (int p = 0; p < NUM_PORTS; p++) begin
      clear = reset || rx_rst[p];
      m_tx_data[p] = (reset || tx_rst[p]) ? '0 : txdata[p*PORT_W +: PORT_W];
      m_tx_k[p] = (reset || tx_rst[p]) ? '0 : txcharisk[p*PORT_BYTES +: PORT_BYTES];
      md = mapped_data(p, m_map_data[p]);
      mk = mapped_k(p, m_map_k[p]);
      for (int b = 0; b < PORT_BYTES; b++) begin
        cur = md[b*BYTE_W +: BYTE_W];
        comma[b] = mk[b] && (cur == K_COMMA);
        align[b] = mk[b] && (cur == K_ALIGN);
        valid[b] = !mk[b] || legal_k(cur);
      end
      m_rx_data[p] = md;
      m_rx_k[p] = mk;
      m_rx_comma[p] = clear ? '0 : comma;
      m_rx_valid[p] = clear ? '0 : valid;
      for (int i = 0; i < NUM_LANES; i++) begin
        n = 0;
        lane_ok = 1'b1;
        saw_align = 1'b0;
        for (int j = 0; j < BYTES_PER_LANE; j++) begin
          n = n + comma[i*BYTES_PER_LANE + j];
          lane_ok = lane_ok && valid[i*BYTES_PER_LANE + j];
          saw_align = saw_align || align[i*BYTES_PER_LANE + j];
        end
        if (clear || !lane_ok) begin
          m_count[p][i] = 0;
        end else if (encommaalign[p*NUM_LANES + i] && (m_count[p][i] < LOCK_COMMAS)) begin
          m_count[p][i] = (m_count[p][i] + n > LOCK_COMMAS) ? LOCK_COMMAS : m_count[p][i] + n;
        end
        m_lock[p][i] = (m_count[p][i] == LOCK_COMMAS);
        m_sync[p][i] = !clear && m_lock[p][i] && (m_sync[p][i] || (enchansync[p] && saw_align));
      end
      m_map_data[p] = clear ? '0 : rx_lane_data[p*PORT_W +: PORT_W];
      m_map_k[p] = clear ? '0 : rx_lane_charisk[p*PORT_BYTES +: PORT_BYTES];
    end
  endtask

  // ========================================
  // Stimulus and cycle loop
  // ========================================
  task automatic pick_byte(output logic [BYTE_W-1:0] b, output logic k);
    int pct;
    pct = $unsigned($random(seed)) % 100;
    b = BYTE_W'($random(seed));
    k = (pct < w_comma + w_align + w_invalid);
    if (pct < w_comma) begin
      b = K_COMMA;
    end else if (pct < w_comma + w_align) begin
      b = K_ALIGN;
    end else if (k) begin
      // Low bits 00000 belong to no legal K code
      b = b & 8'hE0;
    end
  endtask

  task automatic drive_inputs();
    logic [BYTE_W-1:0] b;
    logic k;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int n = 0; n < PORT_BYTES; n++) begin
        pick_byte(b, k);
        // The far end of an inverted port sends the complement
        rx_lane_data[p*PORT_W + n*BYTE_W +: BYTE_W] = RX_INVERT[p] ? ~b : b;
        rx_lane_charisk[p*PORT_BYTES + n] = k;
      end
      txdata[p*PORT_W +: PORT_W] = {$random(seed), $random(seed)};
      txcharisk[p*PORT_BYTES +: PORT_BYTES] = PORT_BYTES'($random(seed));
    end
  endtask

  task automatic check_outputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_data($sformatf("tx_lane_data[%0d]", p), m_tx_data[p],
                 tx_lane_data[p*PORT_W +: PORT_W]);
      check_mask($sformatf("tx_lane_charisk[%0d]", p), m_tx_k[p],
                 tx_lane_charisk[p*PORT_BYTES +: PORT_BYTES]);
      check_data($sformatf("rxdata[%0d]", p), m_rx_data[p], rxdata[p*PORT_W +: PORT_W]);
      check_mask($sformatf("rxcharisk[%0d]", p), m_rx_k[p],
                 rxcharisk[p*PORT_BYTES +: PORT_BYTES]);
      check_mask($sformatf("rxcodecomma[%0d]", p), m_rx_comma[p],
                 rxcodecomma[p*PORT_BYTES +: PORT_BYTES]);
      check_mask($sformatf("rxcodevalid[%0d]", p), m_rx_valid[p],
                 rxcodevalid[p*PORT_BYTES +: PORT_BYTES]);
      check_flags($sformatf("rxlock[%0d]", p), m_lock[p], rxlock[p*NUM_LANES +: NUM_LANES]);
      check_flags($sformatf("rxsyncok[%0d]", p), m_sync[p], rxsyncok[p*NUM_LANES +: NUM_LANES]);
    end
  endtask

  task automatic step();
    drive_inputs();
    update_model();
    @(negedge xaui_clk);
    if (checking) begin
      check_outputs();
    end
  endtask

  task automatic wait_for_all_lanes(input logic want_sync);
    int cycles;
    cycles = 0;
    while (!(&(want_sync ? rxsyncok : rxlock))) begin
      if (cycles == LOCK_TIMEOUT) begin
        stop_with_failure(want_sync ? "Channel sync never arrived on every lane" :
                                      "Lock never arrived on every lane");
      end else begin
        step();
        cycles++;
      end
    end
  endtask

  initial begin
    seed = 32'h8251;
    checking = 1'b0;
    reset = 1'b1;
    tx_rst = '0;
    rx_rst = '0;
    txdata = '0;
    txcharisk = '0;
    rx_lane_data = '0;
    rx_lane_charisk = '0;
    encommaalign = '0;
    enchansync = '0;
    w_comma = 15;
    w_align = 10;
    w_invalid = 15;
    repeat (2) step();
    reset = 1'b0;
    checking = 1'b1;

    // Mixed traffic with transmit resets, illegal K codes and random enables
    repeat (150) begin
      tx_rst = NUM_PORTS'($random(seed));
      encommaalign = FLAT_LANES'($random(seed));
      enchansync = NUM_PORTS'($random(seed));
      step();
    end
    tx_rst = '0;

    // Commas without comma alignment must not lock any lane
    rx_rst = '1;
    step();
    rx_rst = '0;
    encommaalign = '0;
    enchansync = '1;
    w_comma = 50;
    w_align = 10;
    w_invalid = 0;
    repeat (40) step();
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_flags("rxlock unaligned", '0, rxlock[p*NUM_LANES +: NUM_LANES]);
      check_flags("rxsyncok unlocked", '0, rxsyncok[p*NUM_LANES +: NUM_LANES]);
    end

    encommaalign = '1;
    wait_for_all_lanes(1'b0);
    wait_for_all_lanes(1'b1);

    // Receive reset of port 0 leaves port 1 locked and in sync
    rx_rst = 2'b01;
    repeat (2) step();
    check_flags("rxlock port 0", '0, rxlock[0 +: NUM_LANES]);
    check_flags("rxlock port 1", '1, rxlock[NUM_LANES +: NUM_LANES]);
    check_flags("rxsyncok port 1", '1, rxsyncok[NUM_LANES +: NUM_LANES]);
    rx_rst = '0;
    repeat (20) step();

    // One word of illegal K codes drops every lane
    w_comma = 0;
    w_align = 0;
    w_invalid = 100;
    step();
    w_invalid = 0;
    step();
    check_flags("rxlock after invalid", '0, rxlock[0 +: NUM_LANES]);
    check_flags("rxlock after invalid", '0, rxlock[NUM_LANES +: NUM_LANES]);

    w_comma = 20;
    w_align = 10;
    w_invalid = 5;
    repeat (100) begin
      encommaalign = FLAT_LANES'($random(seed));
      enchansync = NUM_PORTS'($random(seed));
      step();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/xaui_infrastructure.sv */
`timescale 1ns/1ns
`default_nettype none

module xaui_infrastructure (
  input  logic xaui_clk,
  input  logic reset,

  input  logic [xaui_pkg::NUM_PORTS-1:0]                       tx_rst,
  input  logic [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_W-1:0]      txdata,
  input  logic [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_BYTES-1:0]  txcharisk,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_W-1:0]      tx_lane_data,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_BYTES-1:0]  tx_lane_charisk,

  input  logic [xaui_pkg::NUM_PORTS-1:0]                       rx_rst,
  input  logic [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_W-1:0]      rx_lane_data,
  input  logic [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_BYTES-1:0]  rx_lane_charisk,
  input  logic [xaui_pkg::NUM_PORTS*xaui_pkg::NUM_LANES-1:0]   encommaalign,
  input  logic [xaui_pkg::NUM_PORTS-1:0]                       enchansync,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_W-1:0]      rxdata,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_BYTES-1:0]  rxcharisk,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_BYTES-1:0]  rxcodecomma,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::PORT_BYTES-1:0]  rxcodevalid,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::NUM_LANES-1:0]   rxsyncok,
  output wire  [xaui_pkg::NUM_PORTS*xaui_pkg::NUM_LANES-1:0]   rxlock
);
  import xaui_pkg::*;

  // Port p sits in slice p of every flat bus
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    xaui_port #(
      .PORT_INDEX (p)
    ) u_port (
      .xaui_clk        (xaui_clk),
      .reset           (reset),
      .tx_rst          (tx_rst[p]),
      .rx_rst          (rx_rst[p]),
      .txdata          (txdata[p*PORT_W +: PORT_W]),
      .txcharisk       (txcharisk[p*PORT_BYTES +: PORT_BYTES]),
      .rx_lane_data    (rx_lane_data[p*PORT_W +: PORT_W]),
      .rx_lane_charisk (rx_lane_charisk[p*PORT_BYTES +: PORT_BYTES]),
      .encommaalign    (encommaalign[p*NUM_LANES +: NUM_LANES]),
      .enchansync      (enchansync[p]),
      .tx_lane_data    (tx_lane_data[p*PORT_W +: PORT_W]),
      .tx_lane_charisk (tx_lane_charisk[p*PORT_BYTES +: PORT_BYTES]),
      .rxdata          (rxdata[p*PORT_W +: PORT_W]),
      .rxcharisk       (rxcharisk[p*PORT_BYTES +: PORT_BYTES]),
      .rxcodecomma     (rxcodecomma[p*PORT_BYTES +: PORT_BYTES]),
      .rxcodevalid     (rxcodevalid[p*PORT_BYTES +: PORT_BYTES]),
      .rxsyncok        (rxsyncok[p*NUM_LANES +: NUM_LANES]),
      .rxlock          (rxlock[p*NUM_LANES +: NUM_LANES])
    );
  end

endmodule

`default_nettype wire

/* hw/xaui_port.sv */
`timescale 1ns/1ns
`default_nettype none

module xaui_port #(
  parameter int PORT_INDEX = 0
) (
  input  logic                  xaui_clk,
  input  logic                  reset,
  input  logic                  tx_rst,
  input  logic                  rx_rst,
  input  xaui_pkg::port_data_t  txdata,
  input  xaui_pkg::port_mask_t  txcharisk,
  input  xaui_pkg::port_data_t  rx_lane_data,
  input  xaui_pkg::port_mask_t  rx_lane_charisk,
  input  xaui_pkg::lane_flags_t encommaalign,
  input  logic                  enchansync,
  output xaui_pkg::port_data_t  tx_lane_data,
  output xaui_pkg::port_mask_t  tx_lane_charisk,
  output xaui_pkg::port_data_t  rxdata,
  output xaui_pkg::port_mask_t  rxcharisk,
  output xaui_pkg::port_mask_t  rxcodecomma,
  output xaui_pkg::port_mask_t  rxcodevalid,
  output xaui_pkg::lane_flags_t rxsyncok,
  output xaui_pkg::lane_flags_t rxlock
);
  import xaui_pkg::*;

  logic rx_reset;

  xaui_lane_if lanes ();

  // ========================================
  // Transmit
  // ========================================
  always_ff @(posedge xaui_clk) begin
    if (reset || tx_rst) begin
      tx_lane_data    <= '0;
      tx_lane_charisk <= '0;
    end else begin
      tx_lane_data    <= txdata;
      tx_lane_charisk <= txcharisk;
    end
  end

  // ========================================
  // Receive
  // ========================================
  // The port's own rx_rst restarts lock without touching other ports
  assign rx_reset = reset | rx_rst;

  xaui_rx_lane_map #(
    .STEER  (RX_LANE_STEER[PORT_INDEX]),
    .INVERT (RX_INVERT[PORT_INDEX])
  ) u_lane_map (
    .xaui_clk     (xaui_clk),
    .reset        (rx_reset),
    .lane_data    (rx_lane_data),
    .lane_charisk (rx_lane_charisk),
    .lanes        (lanes.mapper)
  );

  xaui_rx_sync u_sync (
    .xaui_clk     (xaui_clk),
    .reset        (rx_reset),
    .lanes        (lanes.sync),
    .encommaalign (encommaalign),
    .enchansync   (enchansync),
    .rxdata       (rxdata),
    .rxcharisk    (rxcharisk),
    .rxcodecomma  (rxcodecomma),
    .rxcodevalid  (rxcodevalid),
    .rxsyncok     (rxsyncok),
    .rxlock       (rxlock)
  );

endmodule

`default_nettype wire

/* hw/xaui_rx_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module xaui_rx_sync (
  input  logic                  xaui_clk,
  input  logic                  reset,
  xaui_lane_if.sync             lanes,
  input  xaui_pkg::lane_flags_t encommaalign,
  input  logic                  enchansync,
  output xaui_pkg::port_data_t  rxdata,
  output xaui_pkg::port_mask_t  rxcharisk,
  output xaui_pkg::port_mask_t  rxcodecomma,
  output xaui_pkg::port_mask_t  rxcodevalid,
  output xaui_pkg::lane_flags_t rxsyncok,
  output xaui_pkg::lane_flags_t rxlock
);
  import xaui_pkg::*;

  lock_state_t           state_q [NUM_LANES];
  lock_state_t           state_d [NUM_LANES];
  logic [LOCK_CNT_W-1:0] count_q [NUM_LANES];
  logic [LOCK_CNT_W-1:0] count_d [NUM_LANES];
  lane_flags_t           sync_d;

  // ========================================
  // Per-lane comma lock
  // ========================================
  always_comb begin
    lane_mask_t          lane_valid;
    lane_mask_t          lane_comma;
    lane_mask_t          lane_align;
    logic [LOCK_CNT_W:0] commas;
    logic [LOCK_CNT_W:0] total;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_valid = lanes.code_valid[i*BYTES_PER_LANE +: BYTES_PER_LANE];
      lane_comma = lanes.comma[i*BYTES_PER_LANE +: BYTES_PER_LANE];
      lane_align = lanes.align_char[i*BYTES_PER_LANE +: BYTES_PER_LANE];
      // Commas only count while alignment is enabled on the lane
      commas = encommaalign[i] ? (LOCK_CNT_W+1)'($countones(lane_comma)) : '0;
      total = {1'b0, count_q[i]} + commas;
      state_d[i] = state_q[i];
      count_d[i] = count_q[i];
      if (!(&lane_valid)) begin
        state_d[i] = LOCK_HUNT;
        count_d[i] = '0;
      end else begin
        case (state_q[i])
          LOCK_HUNT, LOCK_COUNT: begin
            if (commas != '0) begin
              if (total >= LOCK_COMMAS) begin
                state_d[i] = LOCK_DONE;
                count_d[i] = LOCK_CNT_W'(LOCK_COMMAS);
              end else begin
                state_d[i] = LOCK_COUNT;
                count_d[i] = total[LOCK_CNT_W-1:0];
              end
            end
          end
          LOCK_DONE: begin
            state_d[i] = LOCK_DONE;
          end
          default: begin
            state_d[i] = LOCK_HUNT;
            count_d[i] = '0;
          end
        endcase
      end
      // Sync is judged against the lock that this word leaves behind
      sync_d[i] = (state_d[i] == LOCK_DONE) &&
                  (rxsyncok[i] || (enchansync && (|lane_align)));
    end
  end

  always_ff @(posedge xaui_clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        state_q[i] <= LOCK_HUNT;
        count_q[i] <= '0;
      end
      rxsyncok    <= '0;
      rxcodecomma <= '0;
      rxcodevalid <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        state_q[i] <= state_d[i];
        count_q[i] <= count_d[i];
      end
      rxsyncok    <= sync_d;
      rxcodecomma <= lanes.comma;
      rxcodevalid <= lanes.code_valid;
    end
  end

  always_ff @(posedge xaui_clk) begin
    rxdata    <= lanes.data;
    rxcharisk <= lanes.charisk;
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rxlock[i] = (state_q[i] == LOCK_DONE);
    end
  end

  // ========================================
  // Checks
  // ========================================
  a_sync_needs_lock: assert property (
    @(posedge xaui_clk) disable iff (reset) (rxsyncok & ~rxlock) == '0
  );

  a_no_lock_after_reset: assert property (
    @(posedge xaui_clk) reset |=> (rxlock == '0)
  );

endmodule

`default_nettype wire

/* hw/xaui_rx_lane_map.sv */
`timescale 1ns/1ns
`default_nettype none

module xaui_rx_lane_map #(
  parameter bit STEER  = 1'b0,
  parameter bit INVERT = 1'b0
) (
  input  logic                 xaui_clk,
  input  logic                 reset,
  input  xaui_pkg::port_data_t lane_data,
  input  xaui_pkg::port_mask_t lane_charisk,
  xaui_lane_if.mapper          lanes
);
  import xaui_pkg::*;

  port_data_t data_q;
  port_mask_t charisk_q;
  lane_data_t lane_word [NUM_LANES];
  lane_mask_t lane_k    [NUM_LANES];

  always_ff @(posedge xaui_clk) begin
    if (reset) begin
      data_q    <= '0;
      charisk_q <= '0;
    end else begin
      data_q    <= lane_data;
      charisk_q <= lane_charisk;
    end
  end

  // ========================================
  // Steering and polarity
  // ========================================
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_word[i] = data_q[i*LANE_W +: LANE_W];
      lane_k[i]    = charisk_q[i*BYTES_PER_LANE +: BYTES_PER_LANE];
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      // A reversed port trades lane i for lane 3-i, K flags go along
      if (STEER) begin
        lanes.data[i*LANE_W +: LANE_W] = lane_word[NUM_LANES-1-i];
        lanes.charisk[i*BYTES_PER_LANE +: BYTES_PER_LANE] = lane_k[NUM_LANES-1-i];
      end else begin
        lanes.data[i*LANE_W +: LANE_W] = lane_word[i];
        lanes.charisk[i*BYTES_PER_LANE +: BYTES_PER_LANE] = lane_k[i];
      end
    end
    // Swapped pair polarity flips the data only
    if (INVERT) begin
      lanes.data = ~lanes.data;
    end
  end

  // ========================================
  // Byte classification
  // ========================================
  always_comb begin
    for (int b = 0; b < PORT_BYTES; b++) begin
      lanes.comma[b] = lanes.charisk[b] && (lanes.data[b*BYTE_W +: BYTE_W] == K_COMMA);
      lanes.align_char[b] = lanes.charisk[b] && (lanes.data[b*BYTE_W +: BYTE_W] == K_ALIGN);
      lanes.code_valid[b] = !lanes.charisk[b] ||
                            k_code_legal(lanes.data[b*BYTE_W +: BYTE_W]);
    end
  end

endmodule

`default_nettype wire

/* hw/xaui_lane_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface xaui_lane_if;
  import xaui_pkg::*;

  // One receive word per clock after steering and inversion
  port_data_t data;
  port_mask_t charisk;

  // Per-byte classification of that same word
  port_mask_t code_valid;
  port_mask_t comma;
  port_mask_t align_char;

  modport mapper (
    output data,
    output charisk,
    output code_valid,
    output comma,
    output align_char
  );

  modport sync (
    input data,
    input charisk,
    input code_valid,
    input comma,
    input align_char
  );

endinterface

`default_nettype wire

/* hw/xaui_pkg.sv */
`default_nettype none

package xaui_pkg;

  // ========================================
  // Port and lane geometry
  // ========================================
  localparam int NUM_PORTS      = 2;
  localparam int NUM_LANES      = 4;
  localparam int BYTES_PER_LANE = 2;
  localparam int BYTE_W         = 8;
  localparam int LANE_W         = BYTES_PER_LANE * BYTE_W;
  localparam int PORT_BYTES     = NUM_LANES * BYTES_PER_LANE;
  localparam int PORT_W         = PORT_BYTES * BYTE_W;

  typedef logic [PORT_W-1:0]         port_data_t;
  typedef logic [PORT_BYTES-1:0]     port_mask_t;
  typedef logic [LANE_W-1:0]         lane_data_t;
  typedef logic [BYTES_PER_LANE-1:0] lane_mask_t;
  typedef logic [NUM_LANES-1:0]      lane_flags_t;

  // ========================================
  // K characters
  // ========================================
  localparam logic [BYTE_W-1:0] K_COMMA = 8'hBC;
  localparam logic [BYTE_W-1:0] K_ALIGN = 8'h7C;

  // K28.0 to K28.7, then K23.7, K27.7, K29.7 and K30.7
  localparam int NUM_K_VALID = 12;
  localparam logic [BYTE_W-1:0] K_VALID_SET [NUM_K_VALID] = '{
    8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC,
    8'hF7, 8'hFB, 8'hFD, 8'hFE
  };

  // Board wiring of each port, bit p belongs to port p
  localparam logic [NUM_PORTS-1:0] RX_LANE_STEER = 2'b01;
  localparam logic [NUM_PORTS-1:0] RX_INVERT     = 2'b10;

  // ========================================
  // Comma lock
  // ========================================
  localparam int LOCK_COMMAS = 4;
  localparam int LOCK_CNT_W  = $clog2(LOCK_COMMAS + 1);

  typedef enum logic [1:0] {
    LOCK_HUNT,
    LOCK_COUNT,
    LOCK_DONE
  } lock_state_t;

  function automatic logic k_code_legal(input logic [BYTE_W-1:0] code);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_K_VALID; i++) begin
      if (code == K_VALID_SET[i]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

endpackage

`default_nettype wire
